/* filelist.f */
+incdir+hdl
hdl/dds_pkg.sv
hdl/modulation_control.sv
hdl/waveform_generator.sv
hdl/keying_modulator.sv
hdl/dds_modulator_top.sv
testbench/tb_dds_modulator.sv

/* Makefile */
# Verilator build for the DDS modulator testbench

VERILATOR ?= verilator
TOP       := tb_dds_modulator
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulator gives pass or fail
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_dds_modulator.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dds_modulator;

   import dds_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // run setup
   //////////////////////////////////////////////////////////////////////

   localparam phase_t TUNING_WORD     = 32'h0348_1F27;   // about 2.6 turns per segment
   localparam int     SEGMENT_SAMPLES = 200;
   localparam int     SETTLE_SAMPLES  = 4;               // skipped after a selection change
   localparam int     FIRST_VALID     = 3;               // edges from release to first valid
   // 8 segments of 200 samples at 2 cycles each is 3200, limit leaves a wide margin
   localparam int     CYCLE_LIMIT     = 20_000;
   localparam real    PI              = 3.14159265358979;

   logic       CLK_25MHZ      = 1'b0;
   logic       reset_from_key = 1'b1;
   scan_code_t key_code       = 8'h00;
   logic       key_valid      = 1'b0;
   phase_t     tuning_word    = TUNING_WORD;
   logic       sample_ready   = 1'b1;
   wire        key_ready;
   wire        sample_valid;
   wire        data_bit;
   wire sample_t carrier_sample;
   wire sample_t modulated_sample;

   logic        random_ready = 1'b0;         // ready held high in the first segment
   logic [31:0] rng_state    = 32'hd0a5_1846;
   int          cycles       = 0;
   int          accepted     = 0;            // transfers so far, polled by the stimulus

   // reference model state
   wave_sel_e model_wave    = WAVE_SINE;
   mod_mode_e model_mode    = MOD_ASK;
   logic      break_pending = 1'b0;
   int        settle        = 0;
   int        sample_index  = 0;
   phase_t    phase_n       = '0;            // n x tuning word
   lfsr_t     prbs          = LFSR_SEED;

   dds_modulator_top dut_i (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .key_code         (key_code),
      .key_valid        (key_valid),
      .key_ready        (key_ready),
      .tuning_word      (tuning_word),
      .sample_ready     (sample_ready),
      .sample_valid     (sample_valid),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample),
      .data_bit         (data_bit)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz

   //////////////////////////////////////////////////////////////////////
   // reference rules
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // quarter wave entry k from the sine itself, bin mid-points
   function automatic int quarter_sine(input int k);
      real angle;
      angle = PI / 2.0 * (real'(k) + 0.5) / 64.0;
      return $rtoi(real'(SAMPLE_MAX) * $sin(angle) + 0.5);
   endfunction

   function automatic int to_sample(input int v);
      return ((v + 2048) & 4095) - 2048;   // wrap to 12 bit signed
   endfunction

   function automatic int expected_wave(input phase_t ph, input wave_sel_e sel);
      phase_t sh;
      int     idx;
      int     result;
      sh  = (sel == WAVE_COSINE) ? ph + QUARTER_PHASE : ph;   // cosine leads by 90 deg
      idx = int'(sh[29:24]);
      case (sel)
         WAVE_SINE, WAVE_COSINE:
         begin
            case (sh[31:30])
               2'd0:    result = quarter_sine(idx);
               2'd1:    result = quarter_sine(63 - idx);         // falling quarter
               2'd2:    result = -quarter_sine(idx);
               default: result = -quarter_sine(63 - idx);
            endcase
         end
         WAVE_SQUARE: result = ph[31] ? -SAMPLE_MAX : SAMPLE_MAX;
         default:     result = int'(ph[31:20]) - (ph[31] ? 4096 : 0);   // top 12 bits signed
      endcase
      return result;
   endfunction

   function automatic int expected_keying(input mod_mode_e mode, input int c, input int h,
                                          input logic d);
      int result;
      case (mode)
         MOD_ASK:  result = d ? c : 0;
         MOD_FSK:  result = d ? h : c;                 // h is the wave at 2p
         MOD_BPSK: result = d ? c : to_sample(-c);
         default:  result = d ? SAMPLE_MAX : -SAMPLE_MAX;
      endcase
      return result;
   endfunction

   function automatic lfsr_t prbs_next(input lfsr_t p);
      return {p[3:0], p[4] ^ p[2]};   // shift left, taps 5 and 3 into bit 0
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string test, input int expected, input int actual);
      stop_run($sformatf("** Error [%s] expected %0d, actual %0d", test, expected, actual));
   endtask

   //////////////////////////////////////////////////////////////////////
   // handshake and stream checks
   //////////////////////////////////////////////////////////////////////

   a_quiet_in_reset : assert property (
      @(posedge CLK_25MHZ) reset_from_key |=> !sample_valid && !key_ready
   ) else stop_run("sample_valid or key_ready was high during reset");

   a_ready_after_reset : assert property (
      @(posedge CLK_25MHZ) !reset_from_key |=> key_ready
   ) else stop_run("key_ready did not stay high after reset");

   a_hold_while_stalled : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      sample_valid && !sample_ready |=>
         sample_valid && $stable(carrier_sample) && $stable(modulated_sample)
         && $stable(data_bit)
   ) else stop_run("sample outputs changed while stalled");

   always @(posedge CLK_25MHZ)
   begin : transfer_check
      int        c_exp;
      int        h_exp;
      int        m_exp;
      logic      d_exp;
      string     tag;
      wave_sel_e new_wave;
      mod_mode_e new_mode;
      // check against the selection that held before this edge
      if (!reset_from_key && sample_valid && sample_ready)
      begin
         c_exp = expected_wave(phase_n, model_wave);
         h_exp = expected_wave(phase_n + phase_n, model_wave);   // 2n x tuning word
         d_exp = prbs[0];
         tag   = $sformatf("%s/%s sample %0d", model_wave.name(), model_mode.name(),
                           sample_index);
         assert (data_bit == d_exp)
            else report_mismatch({tag, " data_bit"}, int'(d_exp), int'(data_bit));
         if (settle == 0)
         begin
            assert (int'(carrier_sample) == c_exp)
               else report_mismatch({tag, " carrier"}, c_exp, int'(carrier_sample));
            m_exp = expected_keying(model_mode, c_exp, h_exp, d_exp);
            assert (int'(modulated_sample) == m_exp)
               else report_mismatch({tag, " modulated"}, m_exp, int'(modulated_sample));
         end
         else
            settle = settle - 1;                 // pipeline still flushing
         sample_index = sample_index + 1;
         phase_n      = phase_n + TUNING_WORD;
         if (sample_index % BIT_SAMPLES == 0)
            prbs = prbs_next(prbs);              // next group of 16
         accepted <= accepted + 1;
      end
      // key decode model
      if (!reset_from_key && key_valid && key_ready)
      begin
         if (break_pending)
            break_pending = 1'b0;                // released key dropped
         else if (key_code == SC_BREAK)
            break_pending = 1'b1;
         else
         begin
            new_wave = model_wave;
            new_mode = model_mode;
            case (key_code)
               SC_KEY_1: new_wave = WAVE_SINE;
               SC_KEY_2: new_wave = WAVE_COSINE;
               SC_KEY_3: new_wave = WAVE_SQUARE;
               SC_KEY_4: new_wave = WAVE_SAW;
               SC_KEY_5: new_mode = MOD_ASK;
               SC_KEY_6: new_mode = MOD_FSK;
               SC_KEY_7: new_mode = MOD_BPSK;
               SC_KEY_8: new_mode = MOD_LFSR;
               default: ;
            endcase
            if (new_wave != model_wave || new_mode != model_mode)
               settle = SETTLE_SAMPLES;
            model_wave = new_wave;
            model_mode = new_mode;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   always @(posedge CLK_25MHZ)
   begin
      if (random_ready)
      begin
         rng_state    <= xorshift32(rng_state);
         sample_ready <= rng_state[0];   // ready about half the time
      end
   end

   always @(posedge CLK_25MHZ)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
         stop_run($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
   end

   task automatic send_key(input scan_code_t code);
      @(posedge CLK_25MHZ);
      key_code  <= code;
      key_valid <= 1'b1;
      do
         @(posedge CLK_25MHZ);
      while (!key_ready);
      key_valid <= 1'b0;   // taken on this edge
   endtask

   task automatic wait_samples(input int count);
      int target;
      target = accepted + count;
      while (accepted < target)
         @(posedge CLK_25MHZ);
   endtask

   initial
   begin : stimulus
      int latency;
      latency = 0;
      repeat (8) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      // first valid, read just after each edge
      do
      begin
         @(posedge CLK_25MHZ);
         #1;
         latency = latency + 1;
      end
      while (!sample_valid && latency < 4 * FIRST_VALID);
      assert (latency == FIRST_VALID)
         else report_mismatch("reset first_valid_latency", FIRST_VALID, latency);

      wait_samples(SEGMENT_SAMPLES);   // default sine with ask
      random_ready <= 1'b1;

      send_key(SC_KEY_2);
      wait_samples(SEGMENT_SAMPLES);
      send_key(SC_KEY_3);
      wait_samples(SEGMENT_SAMPLES);
      send_key(SC_KEY_4);
      wait_samples(SEGMENT_SAMPLES);
      send_key(SC_KEY_1);
      send_key(SC_KEY_6);              // fsk on sine
      wait_samples(SEGMENT_SAMPLES);
      send_key(SC_KEY_7);
      send_key(SC_BREAK);              // release of key 8, stays bpsk
      send_key(SC_KEY_8);
      send_key(8'h1C);                 // letter a, not a control key
      wait_samples(SEGMENT_SAMPLES);
      send_key(SC_KEY_8);
      wait_samples(SEGMENT_SAMPLES);
      send_key(SC_KEY_5);
      send_key(SC_BREAK);
      send_key(SC_KEY_2);              // dropped, wave stays sine
      wait_samples(SEGMENT_SAMPLES);

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/dds_modulator_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dds_modulator_top (
   input  wire                      CLK_25MHZ,
   input  wire                      reset_from_key,
   input  wire dds_pkg::scan_code_t key_code,
   input  wire                      key_valid,
   output wire                      key_ready,
   input  wire dds_pkg::phase_t     tuning_word,
   input  wire                      sample_ready,
   output wire                      sample_valid,
   output wire dds_pkg::sample_t    carrier_sample,
   output wire dds_pkg::sample_t    modulated_sample,
   output wire                      data_bit
);

   import dds_pkg::*;

   logic      advance;    // global stall, low = hold everything
   logic      bit_step;   // prbs step
   wave_sel_e wave_sel;
   mod_mode_e mod_sel;
   sample_t   carrier;    // waveform at p
   sample_t   harmonic;   // waveform at 2p
   logic      gen_valid;

   //////////////////////////////////////////////////////////////////////
   // keys, stall and bit timing
   //////////////////////////////////////////////////////////////////////

   modulation_control ctrl_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_code       (key_code),
      .key_valid      (key_valid),
      .key_ready      (key_ready),
      .sample_valid   (sample_valid),
      .sample_ready   (sample_ready),
      .advance        (advance),
      .bit_step       (bit_step),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel)
   );

   // stages 1 and 2
   waveform_generator gen_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .advance        (advance),
      .tuning_word    (tuning_word),
      .wave_sel       (wave_sel),
      .carrier        (carrier),
      .harmonic       (harmonic),
      .gen_valid      (gen_valid)
   );

   // stage 3
   keying_modulator mod_i (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .advance          (advance),
      .bit_step         (bit_step),
      .mod_sel          (mod_sel),
      .carrier          (carrier),
      .harmonic         (harmonic),
      .gen_valid        (gen_valid),
      .sample_valid     (sample_valid),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample),
      .data_bit         (data_bit)
   );

endmodule

`default_nettype wire

/* hdl/keying_modulator.sv */
`timescale 1ns/100ps
`default_nettype none

module keying_modulator (
   input  wire                     CLK_25MHZ,
   input  wire                     reset_from_key,
   input  wire                     advance,
   input  wire                     bit_step,
   input  wire dds_pkg::mod_mode_e mod_sel,
   input  wire dds_pkg::sample_t   carrier,
   input  wire dds_pkg::sample_t   harmonic,
   input  wire                     gen_valid,
   output logic                    sample_valid,
   output dds_pkg::sample_t        carrier_sample,
   output dds_pkg::sample_t        modulated_sample,
   output logic                    data_bit
);

   import dds_pkg::*;

   lfsr_t   lfsr;
   logic    lfsr_fb;     // feedback, taps 5 and 3
   logic    bit_now;     // data bit for the sample entering the output reg
   sample_t mod_value;

   //////////////////////////////////////////////////////////////////////
   // prbs data source
   //////////////////////////////////////////////////////////////////////

   assign lfsr_fb = lfsr[4] ^ lfsr[2];

   // on a step the entering sample already belongs to the new bit
   assign bit_now = bit_step ? lfsr_fb : lfsr[0];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= LFSR_SEED;
      else if (bit_step)
         lfsr <= {lfsr[3:0], lfsr_fb};   // shift left, fb into bit 0
   end

   // keying of the carrier
   always_comb
   begin
      case (mod_sel)
         MOD_ASK:  mod_value = bit_now ? carrier : '0;           // on/off
         MOD_FSK:  mod_value = bit_now ? harmonic : carrier;     // f or 2f
         MOD_BPSK: mod_value = bit_now ? carrier : -carrier;     // 0 / 180 deg
         default:  mod_value = bit_now ? sample_t'(SAMPLE_MAX)
                                       : sample_t'(-SAMPLE_MAX); // raw bits
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // stage 3, output register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         sample_valid <= 1'b0;
      else if (advance)
         sample_valid <= gen_valid;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (advance)
      begin
         carrier_sample   <= carrier;
         modulated_sample <= mod_value;
         data_bit         <= bit_now;
      end
   end

   // held sample stays put until the sink takes it
   a_stall_stable : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      (sample_valid && !advance) |=>
         sample_valid && $stable({carrier_sample, modulated_sample, data_bit})
   );

endmodule

`default_nettype wire

/* hdl/waveform_generator.sv */
`timescale 1ns/100ps
`default_nettype none

module waveform_generator (
   input  wire                  CLK_25MHZ,
   input  wire                  reset_from_key,
   input  wire                  advance,
   input  wire dds_pkg::phase_t tuning_word,
   input  wire dds_pkg::wave_sel_e wave_sel,
   output dds_pkg::sample_t     carrier,
   output dds_pkg::sample_t     harmonic,
   output logic                 gen_valid
);

   import dds_pkg::*;

`include "sine_quarter_table.svh"

   phase_t phase_acc;     // stage 1, phase of the next sample
   logic   phase_valid;   // goes high one advance after reset

   //////////////////////////////////////////////////////////////////////
   // waveform rules
   //////////////////////////////////////////////////////////////////////

   // quadrant folding of the quarter table
   function automatic sample_t sine_value(input phase_t ph);
      table_index_t idx;
      logic [1:0]   quad;
      idx  = ph[29:24];
      quad = ph[31:30];
      case (quad)
         2'd0:    return sine_value_pos(idx, 1'b0);
         2'd1:    return sine_value_pos(idx, 1'b1);    // falling half
         2'd2:    return -sine_value_pos(idx, 1'b0);
         default: return -sine_value_pos(idx, 1'b1);
      endcase
   endfunction

   // mirror = read table backwards
   function automatic sample_t sine_value_pos(input table_index_t idx, input logic mirror);
      table_index_t addr;
      addr = mirror ? table_index_t'(6'd63 - idx) : idx;
      return sine_quarter[addr];
   endfunction

   function automatic sample_t wave_value(input phase_t ph, input wave_sel_e sel);
      sample_t result;
      case (sel)
         WAVE_SINE:   result = sine_value(ph);
         WAVE_COSINE: result = sine_value(ph + QUARTER_PHASE);   // 90 deg ahead
         WAVE_SQUARE: result = ph[31] ? sample_t'(-SAMPLE_MAX) : sample_t'(SAMPLE_MAX);
         default:     result = sample_t'(ph[31:20]);             // saw, wraps signed
      endcase
      return result;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // stage 1, phase accumulator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase_acc   <= '0;
         phase_valid <= 1'b0;
      end
      else if (advance)
      begin
         if (phase_valid)
            phase_acc <= phase_acc + tuning_word;   // wraps mod 2^32
         phase_valid <= 1'b1;                       // phase 0 now held for sample 0
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage 2, carrier at p and at 2p
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         gen_valid <= 1'b0;
      else if (advance)
         gen_valid <= phase_valid;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (advance)
      begin
         carrier  <= wave_value(phase_acc, wave_sel);
         harmonic <= wave_value({phase_acc[30:0], 1'b0}, wave_sel);   // double rate for fsk
      end
   end

   // a stall must freeze the sample numbering
   a_phase_hold : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      !advance |=> $stable(phase_acc)
   );

endmodule

`default_nettype wire

/* hdl/modulation_control.sv */
`timescale 1ns/100ps
`default_nettype none

module modulation_control (
   input  wire                     CLK_25MHZ,
   input  wire                     reset_from_key,
   input  wire dds_pkg::scan_code_t key_code,
   input  wire                     key_valid,
   output logic                    key_ready,
   input  wire                     sample_valid,
   input  wire                     sample_ready,
   output logic                    advance,
   output logic                    bit_step,
   output dds_pkg::wave_sel_e      wave_sel,
   output dds_pkg::mod_mode_e      mod_sel
);

   import dds_pkg::*;

   key_state_e key_state;
   logic       key_take;   // byte handshake
   logic       transfer;   // sample handshake
   logic [3:0] bit_cnt;    // samples into current data bit

   assign key_take = key_valid & key_ready;
   assign transfer = sample_valid & sample_ready;

   // pipeline moves when output reg is empty or being drained
   assign advance = ~sample_valid | sample_ready;

   // last sample of a bit leaving steps the prbs
   assign bit_step = transfer && (bit_cnt == 4'(BIT_SAMPLES - 1));

   //////////////////////////////////////////////////////////////////////
   // key byte decoder
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         key_ready <= 1'b0;
         key_state <= KEY_IDLE;
         wave_sel  <= WAVE_SINE;
         mod_sel   <= MOD_ASK;
      end
      else
      begin
         key_ready <= 1'b1;   // always able to take a byte
         if (key_take)
         begin
            case (key_state)
               KEY_BREAK: key_state <= KEY_IDLE;   // release code is dropped
               KEY_IDLE:
               begin
                  if (key_code == SC_BREAK)
                     key_state <= KEY_BREAK;
                  else
                  begin
                     case (key_code)
                        SC_KEY_1: wave_sel <= WAVE_SINE;
                        SC_KEY_2: wave_sel <= WAVE_COSINE;
                        SC_KEY_3: wave_sel <= WAVE_SQUARE;
                        SC_KEY_4: wave_sel <= WAVE_SAW;
                        SC_KEY_5: mod_sel  <= MOD_ASK;
                        SC_KEY_6: mod_sel  <= MOD_FSK;
                        SC_KEY_7: mod_sel  <= MOD_BPSK;
                        SC_KEY_8: mod_sel  <= MOD_LFSR;
                        default: ;                 // other keys ignored
                     endcase
                  end
               end
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // samples per bit
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         bit_cnt <= '0;
      else if (transfer)
         bit_cnt <= bit_cnt + 4'd1;   // wraps after 16
   end

   // prbs steps only when a sample really leaves
   a_bit_step_on_transfer : assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      bit_step |-> transfer
   );

endmodule

`default_nettype wire

/* hdl/dds_pkg.sv */
`default_nettype none

package dds_pkg;

   //////////////////////////////////////////////////////////////////////
   // datapath widths
   //////////////////////////////////////////////////////////////////////

   typedef logic        [31:0] phase_t;        // accumulator and tuning word
   typedef logic signed [11:0] sample_t;       // two's complement sample
   typedef logic        [5:0]  table_index_t;  // quarter table address
   typedef logic        [7:0]  scan_code_t;    // one ps/2 set-2 byte
   typedef logic        [4:0]  lfsr_t;         // prbs register

   //////////////////////////////////////////////////////////////////////
   // selections and key fsm
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      WAVE_SINE,
      WAVE_COSINE,
      WAVE_SQUARE,
      WAVE_SAW
   } wave_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK,
      MOD_FSK,
      MOD_BPSK,
      MOD_LFSR
   } mod_mode_e;

   typedef enum logic [0:0] {
      KEY_IDLE,   // next byte is a make code
      KEY_BREAK   // F0 seen, next byte gets dropped
   } key_state_e;

   // constants
   localparam int     SAMPLE_MAX    = 2047;           // full scale
   localparam int     BIT_SAMPLES   = 16;             // samples per data bit
   localparam lfsr_t  LFSR_SEED     = 5'd1;
   localparam phase_t QUARTER_PHASE = 32'h4000_0000;  // 90 degrees

   // scan codes, number row
   localparam scan_code_t SC_BREAK = 8'hF0;
   localparam scan_code_t SC_KEY_1 = 8'h16;  // sine
   localparam scan_code_t SC_KEY_2 = 8'h1E;  // cosine
   localparam scan_code_t SC_KEY_3 = 8'h26;  // square
   localparam scan_code_t SC_KEY_4 = 8'h25;  // saw
   localparam scan_code_t SC_KEY_5 = 8'h2E;  // ask
   localparam scan_code_t SC_KEY_6 = 8'h36;  // fsk
   localparam scan_code_t SC_KEY_7 = 8'h3D;  // bpsk
   localparam scan_code_t SC_KEY_8 = 8'h3E;  // raw lfsr

endpackage

`default_nettype wire

/* hdl/sine_quarter_table.svh */
`ifndef SINE_QUARTER_TABLE_SVH
`define SINE_QUARTER_TABLE_SVH

// first quadrant of the sine, sampled at mid-points of 64 bins
// entry k is round(2047 * sin(pi/2 * (k + 0.5) / 64))
localparam dds_pkg::sample_t sine_quarter [64] = '{
   12'sd25,
   12'sd75,
   12'sd126,
   12'sd176,
   12'sd226,
   12'sd275,
   12'sd325,
   12'sd375,
   12'sd424,
   12'sd473,
   12'sd522,
   12'sd570,
   12'sd618,
   12'sd666,
   12'sd713,
   12'sd760,
   12'sd807,   // index 16
   12'sd852,
   12'sd898,
   12'sd943,
   12'sd987,
   12'sd1031,
   12'sd1074,
   12'sd1116,
   12'sd1158,
   12'sd1199,
   12'sd1239,
   12'sd1279,
   12'sd1318,
   12'sd1356,
   12'sd1393,
   12'sd1430,
   12'sd1465,  // index 32, 45 degrees
   12'sd1500,
   12'sd1533,
   12'sd1566,
   12'sd1598,
   12'sd1629,
   12'sd1659,
   12'sd1688,
   12'sd1716,
   12'sd1743,
   12'sd1769,
   12'sd1793,
   12'sd1817,
   12'sd1840,
   12'sd1861,
   12'sd1881,
   12'sd1901,  // index 48
   12'sd1919,
   12'sd1936,
   12'sd1951,
   12'sd1966,
   12'sd1979,
   12'sd1992,
   12'sd2003,
   12'sd2012,
   12'sd2021,
   12'sd2028,
   12'sd2035,
   12'sd2039,
   12'sd2043,
   12'sd2046,
   12'sd2047   // top of the quadrant
};

`endif
